//--- common/cd_defines.svh
`ifndef CD_DEFINES_SVH
`define CD_DEFINES_SVH

// Host data word and sector header length field
`define CD_WORD_W 16
`define CD_LEN_W 15

// Word buffer between loader and unpacker
`define CD_FIFO_DEPTH 8
`define CD_CREDIT_W 4

// Mailbox frame fields
`define CD_COMM_W 96
`define CD_DOUT_W 80
`define CD_TAG_W 16

`endif

//--- common/cd_link_pkg.sv
`default_nettype none

`include "cd_defines.svh"

package cd_link_pkg;

  // Tag values of frames sent toward the host
  typedef enum logic [`CD_TAG_W-1:0] {
    LINK_COMM     = 16'h0000,
    LINK_DOUT     = 16'h0001,
    LINK_DATA_END = 16'h0002,
    LINK_RESET    = 16'h00FF
  } link_op_e;

  typedef struct packed {
    logic comm_send;
    logic dout_send;
    logic data_end;
    logic reset_req;
  } link_req_t;

  typedef struct packed {
    logic                  toggle;
    logic [`CD_TAG_W-1:0]  tag;
    logic [`CD_COMM_W-1:0] payload;
  } link_frame_t;

  // Status byte in [7:0], message byte in [15:8]
  typedef struct packed {
    logic        toggle;
    logic [93:0] unused;
    logic        region;
    logic        dout_req;
    logic [15:0] stat;
  } link_status_t;

endpackage

`default_nettype wire

//--- common/cd_data_pkg.sv
`default_nettype none

`include "cd_defines.svh"

package cd_data_pkg;

  // First word of a sector download
  typedef struct packed {
    logic                 dm;
    logic [`CD_LEN_W-1:0] len;
  } sector_hdr_t;

  // Half means only the low byte carries data
  typedef struct packed {
    logic                  half;
    logic                  last;
    logic [`CD_WORD_W-1:0] word;
  } word_beat_t;

  typedef enum logic [1:0] {
    UNPACK_IDLE,
    UNPACK_STROBE,
    UNPACK_GAP,
    UNPACK_NEXT
  } unpack_state_e;

  typedef enum logic [1:0] {
    LOAD_IDLE,
    LOAD_HEADER,
    LOAD_PAYLOAD
  } loader_state_e;

endpackage

`default_nettype wire

//--- cd_link/cd_mailbox.sv
`timescale 1ns/1ps
`default_nettype none

`include "cd_defines.svh"

module cd_mailbox
  import cd_link_pkg::*;
(
  input  wire                  clk_sys_42_95,
  input  wire                  reset,
  input  wire                  cd_en,
  input  wire link_req_t       core_req,
  input  wire [`CD_COMM_W-1:0] cd_comm,
  input  wire [`CD_DOUT_W-1:0] cd_dataout,
  input  wire link_status_t    host_status,
  output link_frame_t          host_frame,
  output logic [15:0]          cd_stat,
  output logic                 cd_stat_get,
  output logic                 cd_dout_req,
  output logic                 cd_region
);

  link_req_t req_q;
  link_req_t req_rise;
  link_op_e  op;
  logic      status_toggle_q;

  assign req_rise = link_req_t'(core_req & ~req_q);

  // Only one edge wins per cycle, others are dropped
  always_comb begin
    op = LINK_RESET;
    if (req_rise.comm_send) begin
      op = LINK_COMM;
    end else if (req_rise.dout_send) begin
      op = LINK_DOUT;
    end else if (req_rise.data_end) begin
      op = LINK_DATA_END;
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      req_q      <= '0;
      host_frame <= '0;
    end else begin
      req_q <= core_req;
      if (|req_rise) begin
        host_frame.toggle <= ~host_frame.toggle;
        case (op)
          LINK_COMM: begin
            host_frame.payload <= cd_comm;
            host_frame.tag     <= {cd_en, 15'(LINK_COMM)};
          end
          LINK_DOUT: begin
            // Upper payload bits stay from the previous frame
            host_frame.payload[`CD_DOUT_W-1:0] <= cd_dataout;
            host_frame.tag                     <= LINK_DOUT;
          end
          default: host_frame.tag <= op;
        endcase
      end
    end
  end

  // Host status frame, a toggle flip marks a new one
  always_ff @(posedge clk_sys_42_95) begin
    cd_stat_get <= 1'b0;
    cd_dout_req <= 1'b0;
    if (reset) begin
      // Follow the host toggle so leaving reset gives no pulse
      status_toggle_q <= host_status.toggle;
      cd_region       <= 1'b0;
    end else if (host_status.toggle != status_toggle_q) begin
      status_toggle_q <= host_status.toggle;
      cd_stat_get     <= ~host_status.dout_req;
      cd_dout_req     <= host_status.dout_req;
      cd_region       <= host_status.region;
    end
  end

  // Status word is payload only
  always_ff @(posedge clk_sys_42_95) begin
    if (host_status.toggle != status_toggle_q) begin
      cd_stat <= host_status.stat;
    end
  end

endmodule

`default_nettype wire

//--- cd_data/cd_sector_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "cd_defines.svh"

module cd_sector_loader
  import cd_data_pkg::*;
(
  input  wire                  clk_sys_42_95,
  input  wire                  reset,
  input  wire                  cd_dat_download,
  input  wire                  cdctl_wr,
  input  wire [`CD_WORD_W-1:0] cd_data_out,
  input  wire                  credit_return,
  output logic                 cd_dat_ready,
  output logic                 cd_dm,
  output logic                 push,
  output word_beat_t           beat
);

  localparam logic [`CD_CREDIT_W-1:0] CREDIT_MAX = `CD_FIFO_DEPTH;

  loader_state_e           state;
  sector_hdr_t             hdr;
  logic                    dl_q;
  logic                    dl_rise;
  logic                    wr_ok;
  logic [`CD_CREDIT_W-1:0] credits;
  logic [`CD_LEN_W-1:0]    words_left;
  logic                    odd_len;

  assign hdr     = sector_hdr_t'(cd_data_out);
  assign dl_rise = cd_dat_download & ~dl_q;

  // Payload writes need a free buffer entry
  assign cd_dat_ready = (state == LOAD_HEADER) ||
                        ((state == LOAD_PAYLOAD) && (credits != '0) && (words_left != '0));
  assign wr_ok = cdctl_wr & cd_dat_ready;
  assign push  = wr_ok && (state == LOAD_PAYLOAD);

  always_comb begin
    beat.word = cd_data_out;
    beat.last = (words_left == `CD_LEN_W'(1));
    beat.half = beat.last & odd_len;
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      state      <= LOAD_IDLE;
      dl_q       <= 1'b0;
      cd_dm      <= 1'b0;
      words_left <= '0;
      odd_len    <= 1'b0;
    end else begin
      dl_q <= cd_dat_download;
      if (dl_rise) begin
        state <= LOAD_HEADER;
      end else begin
        case (state)
          LOAD_HEADER: if (wr_ok) begin
            cd_dm      <= hdr.dm;
            // Byte length rounded up to whole words
            words_left <= (hdr.len >> 1) + {{(`CD_LEN_W-1){1'b0}}, hdr.len[0]};
            odd_len    <= hdr.len[0];
            state      <= LOAD_PAYLOAD;
          end
          LOAD_PAYLOAD: begin
            if (words_left == '0) begin
              state <= LOAD_IDLE;
            end else if (push) begin
              words_left <= words_left - 1'b1;
            end
          end
          default: state <= LOAD_IDLE;
        endcase
      end
    end
  end

  // Credit counter, one spent per push and one back per pop
  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      credits <= CREDIT_MAX;
    end else begin
      case ({push, credit_return})
        2'b10:   credits <= credits - 1'b1;
        2'b01:   credits <= credits + 1'b1;
        default: credits <= credits;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- cd_data/cd_word_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "cd_defines.svh"

module cd_word_fifo
  import cd_data_pkg::*;
(
  input  wire             clk_sys_42_95,
  input  wire             reset,
  input  wire             push,
  input  wire word_beat_t beat_in,
  input  wire             pop,
  output word_beat_t      beat_out,
  output logic            not_empty,
  output logic            credit_return
);

  localparam int AW = $clog2(`CD_FIFO_DEPTH);

  word_beat_t    mem [`CD_FIFO_DEPTH];
  logic [AW:0]   wr_ptr;
  logic [AW:0]   rd_ptr;
  logic          do_pop;

  // Extra pointer bit tells full from empty
  assign not_empty = (wr_ptr != rd_ptr);
  assign do_pop    = pop & not_empty;

  // Head entry is always visible
  assign beat_out = mem[rd_ptr[AW-1:0]];

  always_ff @(posedge clk_sys_42_95) begin
    if (push) begin
      mem[wr_ptr[AW-1:0]] <= beat_in;
    end
  end

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      credit_return <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // One credit back per popped word
      credit_return <= do_pop;
    end
  end

endmodule

`default_nettype wire

//--- cd_data/cd_byte_unpacker.sv
`timescale 1ns/1ps
`default_nettype none

`include "cd_defines.svh"

module cd_byte_unpacker
  import cd_data_pkg::*;
(
  input  wire             clk_sys_42_95,
  input  wire             reset,
  input  wire word_beat_t beat,
  input  wire             not_empty,
  output logic            pop,
  output logic [7:0]      cd_data,
  output logic            cd_wr
);

  localparam int BYTE_W = `CD_WORD_W / 2;

  unpack_state_e     state;
  logic [BYTE_W-1:0] hi_byte;
  logic              hi_pending;

  assign pop   = (state == UNPACK_IDLE) && not_empty;
  assign cd_wr = (state == UNPACK_STROBE);

  // Low byte, gap, then high byte unless the word is a half word
  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      state      <= UNPACK_IDLE;
      hi_pending <= 1'b0;
    end else begin
      case (state)
        UNPACK_IDLE: if (not_empty) begin
          hi_pending <= ~beat.half;
          state      <= UNPACK_STROBE;
        end
        UNPACK_STROBE: state <= UNPACK_GAP;
        UNPACK_GAP: begin
          if (hi_pending) begin
            hi_pending <= 1'b0;
            state      <= UNPACK_NEXT;
          end else begin
            state <= UNPACK_IDLE;
          end
        end
        UNPACK_NEXT: state <= UNPACK_STROBE;
        default: state <= UNPACK_IDLE;
      endcase
    end
  end

  // Byte lanes, held steady between strobes
  always_ff @(posedge clk_sys_42_95) begin
    if (pop) begin
      cd_data <= beat.word[BYTE_W-1:0];
      hi_byte <= beat.word[`CD_WORD_W-1:BYTE_W];
    end else if (state == UNPACK_NEXT) begin
      cd_data <= hi_byte;
    end
  end

endmodule

`default_nettype wire

//--- hw/cd_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cd_defines.svh"

module cd_bridge_top
  import cd_link_pkg::*;
  import cd_data_pkg::*;
(
  input  wire                    clk_sys_42_95,
  input  wire                    reset,
  input  wire                    cd_en,
  input  wire link_status_t      host_status,
  input  wire link_req_t         core_req,
  input  wire [`CD_COMM_W-1:0]   cd_comm,
  input  wire [`CD_DOUT_W-1:0]   cd_dataout,
  input  wire                    cd_dat_download,
  input  wire                    cdctl_wr,
  input  wire [`CD_WORD_W-1:0]   cd_data_out,
  output link_frame_t            host_frame,
  output logic [15:0]            cd_stat,
  output logic                   cd_stat_get,
  output logic                   cd_dout_req,
  output logic                   cd_region,
  output logic                   cd_dat_ready,
  output logic [7:0]             cd_data,
  output logic                   cd_wr,
  output logic                   cd_dm
);

  logic       push;
  word_beat_t beat_push;
  logic       pop;
  word_beat_t beat_pop;
  logic       not_empty;
  logic       credit_return;

  // Host mailbox, independent of the sector data path
  cd_mailbox u_mailbox (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .cd_en         (cd_en),
    .core_req      (core_req),
    .cd_comm       (cd_comm),
    .cd_dataout    (cd_dataout),
    .host_status   (host_status),
    .host_frame    (host_frame),
    .cd_stat       (cd_stat),
    .cd_stat_get   (cd_stat_get),
    .cd_dout_req   (cd_dout_req),
    .cd_region     (cd_region)
  );

  cd_sector_loader u_loader (
    .clk_sys_42_95   (clk_sys_42_95),
    .reset           (reset),
    .cd_dat_download (cd_dat_download),
    .cdctl_wr        (cdctl_wr),
    .cd_data_out     (cd_data_out),
    .credit_return   (credit_return),
    .cd_dat_ready    (cd_dat_ready),
    .cd_dm           (cd_dm),
    .push            (push),
    .beat            (beat_push)
  );

  cd_word_fifo u_fifo (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .push          (push),
    .beat_in       (beat_push),
    .pop           (pop),
    .beat_out      (beat_pop),
    .not_empty     (not_empty),
    .credit_return (credit_return)
  );

  cd_byte_unpacker u_unpacker (
    .clk_sys_42_95 (clk_sys_42_95),
    .reset         (reset),
    .beat          (beat_pop),
    .not_empty     (not_empty),
    .pop           (pop),
    .cd_data       (cd_data),
    .cd_wr         (cd_wr)
  );

endmodule

`default_nettype wire

//--- test/cd_bridge_assertions.sv
`timescale 1ns/1ps
`default_nettype none

`include "cd_defines.svh"

module cd_bridge_assertions (
  input wire clk_sys_42_95,
  input wire reset,
  input wire cd_wr,
  input wire cd_stat_get,
  input wire cd_dout_req,
  input wire push,
  input wire credit_return
);

  // Shadow of the loader credit count, rebuilt from push and return
  int credits;

  always_ff @(posedge clk_sys_42_95) begin
    if (reset) begin
      credits <= `CD_FIFO_DEPTH;
    end else begin
      credits <= credits - int'(push) + int'(credit_return);
    end
  end

  a_wr_gap: assert property (@(posedge clk_sys_42_95) disable iff (reset)
    cd_wr |=> !cd_wr)
    else $error("cd_wr high in two consecutive cycles");

  a_credit_max: assert property (@(posedge clk_sys_42_95) disable iff (reset)
    credits <= `CD_FIFO_DEPTH)
    else $error("credit count above buffer depth");

  a_push_credit: assert property (@(posedge clk_sys_42_95) disable iff (reset)
    push |-> credits > 0)
    else $error("word pushed with no credit left");

  a_one_pulse: assert property (@(posedge clk_sys_42_95) disable iff (reset)
    !(cd_stat_get && cd_dout_req))
    else $error("status get and data-out request high together");

endmodule

bind cd_bridge_top cd_bridge_assertions u_assertions (
  .clk_sys_42_95 (clk_sys_42_95),
  .reset         (reset),
  .cd_wr         (cd_wr),
  .cd_stat_get   (cd_stat_get),
  .cd_dout_req   (cd_dout_req),
  .push          (push),
  .credit_return (credit_return)
);

`default_nettype wire

//--- test/cd_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cd_defines.svh"

module cd_bridge_tb
  import cd_link_pkg::*;
  import cd_data_pkg::*;
();

  localparam int EVEN_LEN = 24;
  localparam int ODD_LEN  = 37;
  // Fixed margin plus up to 16 cycles for every byte
  localparam int WATCHDOG_CYCLES = 600 + 16 * (EVEN_LEN + ODD_LEN);

  logic                  clk_sys_42_95;
  logic                  reset;
  logic                  cd_en;
  link_status_t          host_status;
  link_req_t             core_req;
  logic [`CD_COMM_W-1:0] cd_comm;
  logic [`CD_DOUT_W-1:0] cd_dataout;
  logic                  cd_dat_download;
  logic                  cdctl_wr;
  logic [`CD_WORD_W-1:0] cd_data_out;
  link_frame_t           host_frame;
  logic [15:0]           cd_stat;
  logic                  cd_stat_get;
  logic                  cd_dout_req;
  logic                  cd_region;
  logic                  cd_dat_ready;
  logic [7:0]            cd_data;
  logic                  cd_wr;
  logic                  cd_dm;

  int           tests;
  int           checks;
  int           errors;
  int           err_mark;
  int           got_count;
  link_frame_t  model_frame;
  link_status_t model_status;
  logic [15:0]  words[$];
  logic [7:0]   exp_bytes[$];

  cd_bridge_top DUT (.*);

  initial clk_sys_42_95 = 1'b0;
  always #5 clk_sys_42_95 = ~clk_sys_42_95;

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("Watchdog expired, the run did not finish in time");
    $display("Something failed");
    $finish;
  end

  // Expected frame after the request edges in rise
  function automatic link_frame_t ref_frame(input link_frame_t prev, input link_req_t rise,
                                            input logic en, input logic [95:0] comm,
                                            input logic [79:0] dout);
    link_frame_t f;
    f = prev;
    if (rise != '0) begin
      f.toggle = ~prev.toggle;
      if (rise.comm_send) begin
        f.payload = comm;
        f.tag     = {en, 15'h0000};
      end else if (rise.dout_send) begin
        f.payload[79:0] = dout;
        f.tag           = 16'h0001;
      end else if (rise.data_end) begin
        f.tag = 16'h0002;
      end else begin
        f.tag = 16'h00FF;
      end
    end
    return f;
  endfunction

  // Byte i of the sector is byte i%2 of word i/2 with the low byte first
  function automatic void ref_bytes(input int len);
    exp_bytes.delete();
    for (int i = 0; i < len; i++) begin
      exp_bytes.push_back(i[0] ? words[i/2][15:8] : words[i/2][7:0]);
    end
  endfunction

  task automatic check_frame(input link_frame_t got, input link_frame_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s frame toggle %b tag %h payload %h", $time, what,
               got.toggle, got.tag, got.payload);
      $display("     expected toggle %b tag %h payload %h", exp.toggle, exp.tag, exp.payload);
    end
  endtask

  task automatic check_status(input logic [15:0] stat, input logic region, input logic get,
                              input logic dreq, input link_status_t exp, input logic pulse);
    checks++;
    if (stat !== exp.stat || region !== exp.region ||
        get !== (pulse & ~exp.dout_req) || dreq !== (pulse & exp.dout_req)) begin
      errors++;
      $display("FAIL %0t: status %h region %b get %b dout_req %b, expected %h %b %b %b",
               $time, stat, region, get, dreq, exp.stat, exp.region,
               pulse & ~exp.dout_req, pulse & exp.dout_req);
    end
  endtask

  task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input int idx);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: byte %0d is %h, expected %h", $time, idx, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic end_test(input string name);
    tests++;
    $display("test %0d %s: %0d errors", tests, name, errors - err_mark);
    err_mark = errors;
  endtask

  // Compares every strobed byte against the reference list
  always @(posedge clk_sys_42_95) begin
    if (!reset && cd_wr) begin
      if (got_count < exp_bytes.size()) begin
        check_byte(cd_data, exp_bytes[got_count], got_count);
      end else begin
        errors++;
        $display("FAIL %0t: extra byte %h after %0d bytes", $time, cd_data, got_count);
      end
      got_count++;
    end
  end

  task automatic frame_test(input link_req_t req, input string name);
    link_frame_t exp;
    @(negedge clk_sys_42_95);
    cd_en      = ~cd_en;
    cd_comm    = {$urandom(), $urandom(), $urandom()};
    cd_dataout = {$urandom(), $urandom(), 16'($urandom())};
    core_req   = req;
    exp         = ref_frame(model_frame, req, cd_en, cd_comm, cd_dataout);
    model_frame = exp;
    @(negedge clk_sys_42_95);
    check_frame(host_frame, exp, name);
    core_req = '0;
    @(negedge clk_sys_42_95);
    check_frame(host_frame, exp, name);
  endtask

  task automatic status_test(input logic flip);
    link_status_t s;
    s = link_status_t'({$urandom(), $urandom(), $urandom(), 17'($urandom())});
    s.toggle = flip ? ~host_status.toggle : host_status.toggle;
    if (flip) begin
      model_status = s;
    end
    @(negedge clk_sys_42_95);
    host_status = s;
    @(negedge clk_sys_42_95);
    check_status(cd_stat, cd_region, cd_stat_get, cd_dout_req, model_status, flip);
    @(negedge clk_sys_42_95);
    check_status(cd_stat, cd_region, cd_stat_get, cd_dout_req, model_status, 1'b0);
  endtask

  // rate is the chance in percent that the host writes when ready
  task automatic download(input int len, input logic dm, input int rate);
    sector_hdr_t hdr;
    int          n_words;
    int          sent;
    int          cycles;
    int          limit;
    n_words = (len + 1) / 2;
    limit   = 50 + 16 * len;
    words.delete();
    for (int i = 0; i < n_words; i++) begin
      words.push_back(16'($urandom()));
    end
    ref_bytes(len);
    got_count = 0;
    hdr.dm    = dm;
    hdr.len   = 15'(len);
    @(negedge clk_sys_42_95);
    cd_dat_download = 1'b1;
    @(negedge clk_sys_42_95);
    check_bit(cd_dat_ready, 1'b1, "cd_dat_ready for header");
    cdctl_wr    = 1'b1;
    cd_data_out = hdr;
    @(negedge clk_sys_42_95);
    cdctl_wr        = 1'b0;
    cd_dat_download = 1'b0;
    check_bit(cd_dm, dm, "cd_dm");
    check_bit(cd_dat_ready, n_words != 0, "cd_dat_ready after header");
    sent   = 0;
    cycles = 0;
    while ((sent < n_words || got_count < len) && cycles < limit) begin
      if (sent < n_words && cd_dat_ready && ($urandom() % 100) < rate) begin
        cdctl_wr    = 1'b1;
        cd_data_out = words[sent];
        sent++;
      end else begin
        cdctl_wr    = 1'b0;
        cd_data_out = 16'($urandom());
      end
      @(negedge clk_sys_42_95);
      cycles++;
    end
    cdctl_wr = 1'b0;
    if (cycles >= limit) begin
      errors++;
      $display("Download of %0d bytes stalled after %0d cycles", len, cycles);
    end
    // Let any stray strobe show up before counting
    repeat (8) @(negedge clk_sys_42_95);
    checks++;
    if (got_count != len) begin
      errors++;
      $display("FAIL %0t: %0d bytes strobed, expected %0d", $time, got_count, len);
    end
  endtask

  initial begin
    void'($urandom(32'h82ae));
    reset           = 1'b1;
    cd_en           = 1'b0;
    host_status     = '0;
    core_req        = '0;
    cd_comm         = '0;
    cd_dataout      = '0;
    cd_dat_download = 1'b0;
    cdctl_wr        = 1'b0;
    cd_data_out     = '0;
    model_frame     = '0;
    model_status    = '0;
    got_count       = 0;
    repeat (4) @(negedge clk_sys_42_95);
    reset = 1'b0;
    @(negedge clk_sys_42_95);

    check_frame(host_frame, '0, "reset");
    check_bit(cd_wr, 1'b0, "cd_wr");
    check_bit(cd_stat_get, 1'b0, "cd_stat_get");
    check_bit(cd_dout_req, 1'b0, "cd_dout_req");
    check_bit(cd_region, 1'b0, "cd_region");
    check_bit(cd_dm, 1'b0, "cd_dm");
    check_bit(cd_dat_ready, 1'b0, "cd_dat_ready");
    end_test("reset state");

    frame_test(4'b1000, "command");
    frame_test(4'b0100, "data-out");
    frame_test(4'b0010, "data-end");
    frame_test(4'b0001, "drive reset");
    frame_test(4'b1000, "command");
    frame_test(4'b1111, "all edges");
    frame_test(4'b0110, "data-out over data-end");
    frame_test(4'b0011, "data-end over reset");
    end_test("request frames");

    for (int i = 0; i < 6; i++) begin
      status_test(1'b1);
      status_test(1'b0);
    end
    end_test("host status");

    download(EVEN_LEN, 1'b1, 100);
    end_test("even download");
    download(0, 1'b0, 100);
    end_test("empty download");
    download(ODD_LEN, 1'b0, 50);
    end_test("odd paced download");

    $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/cd_link_pkg.sv
common/cd_data_pkg.sv
cd_link/cd_mailbox.sv
cd_data/cd_sector_loader.sv
cd_data/cd_word_fifo.sv
cd_data/cd_byte_unpacker.sv
hw/cd_bridge_top.sv
test/cd_bridge_assertions.sv
test/cd_bridge_tb.sv

//--- Makefile
TOOL      = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = cd_bridge_tb
FILE_LIST = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
